// ==== verif/ex_tests.txt ====
# op type addr rs rt rd s t imm uns hilo cp0 | wb_data wb_addr ovf mem_op mem_sz mem_addr
# hilo_we hilo_value cp0_we cp0_wr cp0_rd cp0_sel strobes{syscall,eret,tlb,priv}, all hex
01 0 0 1 2 3 5 7 0 0 0 0 c 3 0 0 2 0 0 0 0 0 0 0 0
01 0 0 1 2 3 7fffffff 1 0 0 0 0 0 0 1 0 2 0 0 0 0 0 0 0 0
01 1 0 1 2 3 10 0 fffe 0 0 0 e 2 0 0 2 0 0 0 0 0 0 0 0
02 0 0 1 2 3 80000000 1 0 0 0 0 0 0 1 0 2 0 0 0 0 0 0 0 0
02 0 0 1 2 3 0 1 0 1 0 0 ffffffff 3 0 0 2 0 0 0 0 0 0 0 0
03 0 0 1 2 3 ff00ff00 0f0f0f0f 0 0 0 0 0f000f00 3 0 0 2 0 0 0 0 0 0 0 0
04 1 0 1 2 3 12340000 0 8001 0 0 0 12348001 2 0 0 2 0 0 0 0 0 0 0 0
05 1 0 1 2 3 ffffffff 0 ffff 0 0 0 ffff0000 2 0 0 2 0 0 0 0 0 0 0 0
06 0 0 1 2 3 f0f0f0f0 0f0f0000 0 0 0 0 00000f0f 3 0 0 2 0 0 0 0 0 0 0 0
0e 1 0 1 2 3 0 0 abcd 0 0 0 abcd0000 2 0 0 2 0 0 0 0 0 0 0 0
07 0 0 1 2 3 ffffffff 1 0 0 0 0 1 3 0 0 2 0 0 0 0 0 0 0 0
07 0 0 1 2 3 ffffffff 1 0 1 0 0 0 3 0 0 2 0 0 0 0 0 0 0 0
08 0 0 1 2 3 0 3 4 0 0 0 30 3 0 0 2 0 0 0 0 0 0 0 0
09 0 0 1 2 3 0 80000000 1f 0 0 0 1 3 0 0 2 0 0 0 0 0 0 0 0
0a 0 0 1 2 3 0 80000000 4 0 0 0 f8000000 3 0 0 2 0 0 0 0 0 0 0 0
0b 0 0 1 2 3 4 1 0 0 0 0 10 3 0 0 2 0 0 0 0 0 0 0 0
0c 0 0 1 2 3 18 ff000000 0 0 0 0 ff 3 0 0 2 0 0 0 0 0 0 0 0
0d 0 0 1 2 3 8 f0000000 0 0 0 0 fff00000 3 0 0 2 0 0 0 0 0 0 0 0
0f 0 0 1 2 3 ffffffff 0 0 0 0 0 20 3 0 0 2 0 0 0 0 0 0 0 0
0f 0 0 1 2 3 f0000000 0 0 0 0 0 4 3 0 0 2 0 0 0 0 0 0 0 0
10 0 0 1 2 3 0 0 0 0 0 0 20 3 0 0 2 0 0 0 0 0 0 0 0
10 0 0 1 2 3 00010000 0 0 0 0 0 f 3 0 0 2 0 0 0 0 0 0 0 0
11 0 0 1 2 3 deadbeef 1 0 0 0 0 deadbeef 3 0 0 2 0 0 0 0 0 0 0 0
11 0 0 1 2 3 deadbeef 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0
12 0 0 1 2 3 5 1 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0
12 0 0 1 2 3 5 0 0 0 0 0 5 3 0 0 2 0 0 0 0 0 0 0 0
13 2 400008 1 2 3 0 0 0 0 0 0 400008 1f 0 0 2 0 0 0 0 0 0 0 0
15 1 400010 1 2 3 0 0 0 0 0 0 400010 1f 0 0 2 0 0 0 0 0 0 0 0
16 1 400014 1 2 3 0 0 0 0 0 0 400014 1f 0 0 2 0 0 0 0 0 0 0 0
14 0 400018 1 2 3 0 0 0 0 0 0 400018 3 0 0 2 0 0 0 0 0 0 0 0
19 1 0 1 2 3 1000 0 fffc 0 0 0 0 2 0 1 2 ffc 0 0 0 0 0 0 0
18 1 0 1 2 3 100 0 2 0 0 0 0 2 0 1 1 102 0 0 0 0 0 0 0
1b 1 0 1 2 3 2000 aa 10 0 0 0 aa 2 0 2 0 2010 0 0 0 0 0 0 0
1d 1 0 1 2 3 0 1 8000 0 0 0 1 2 0 2 2 ffff8000 0 0 0 0 0 0 0
1f 0 0 1 2 3 0 0 0 0 1111111122222222 0 11111111 3 0 0 2 0 0 0 0 0 0 0 0
20 0 0 1 2 3 0 0 0 0 1111111122222222 0 22222222 3 0 0 2 0 0 0 0 0 0 0 0
21 0 0 1 2 3 aaaaaaaa 0 0 0 1111111122222222 0 0 0 0 0 2 0 1 aaaaaaaa22222222 0 0 0 0 0
22 0 0 1 2 3 aaaaaaaa 0 0 0 1111111122222222 0 0 0 0 0 2 0 1 11111111aaaaaaaa 0 0 0 0 0
26 0 0 1 2 3 fffffffe 3 0 0 0 0 0 0 0 0 2 0 1 fffffffffffffffa 0 0 0 0 0
26 0 0 1 2 3 ffffffff 2 0 1 0 0 0 0 0 0 2 0 1 00000001fffffffe 0 0 0 0 0
25 0 0 1 2 3 7 6 0 0 0 0 2a 3 0 0 2 0 0 0 0 0 0 0 0
27 0 0 1 2 3 2 3 0 0 10 0 0 0 0 0 2 0 1 16 0 0 0 0 0
28 0 0 1 2 3 2 3 0 0 0 0 0 0 0 0 2 0 1 fffffffffffffffa 0 0 0 0 0
29 0 0 1 2 3 fffffff9 2 0 0 0 0 0 0 0 0 2 0 1 fffffffffffffffd 0 0 0 0 0
29 0 0 1 2 3 64 7 0 1 0 0 0 0 0 0 2 0 1 000000020000000e 0 0 0 0 0
23 0 0 1 2 c 0 0 1 0 0 cafef00d cafef00d 2 0 0 2 0 0 0 0 0 c 1 1
24 0 0 1 2 c 0 12345678 0 0 0 0 12345678 0 0 0 2 0 0 0 1 c 0 0 1
2a 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 8
2b 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 5
2c 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 3
2d 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 1
00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 0 0 0 0 0 0 0

// ==== filelist.f ====
rtl/ex_pkg.sv
rtl/count_bit_word.sv
rtl/alu_unit.sv
rtl/muldiv_unit.sv
rtl/ex_combine.sv
rtl/ex_stage.sv
verif/tb_clock.sv
verif/ex_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module ex_tb \
    --Mdir obj_dir -o ex_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/ex_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation reported failures, see sim.log"
    exit 1
fi

// ==== verif/ex_tb.sv ====
`default_nettype none

module ex_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ex_pkg::*;

    localparam string DATA_FILE = "verif/ex_tests.txt";
    localparam int    MAX_TESTS = 64;
    localparam int    NFIELDS   = 25;

    logic        clk;
    logic        rst_n;
    logic        flush;
    ex_req_t     req;
    logic [63:0] hilo_value;
    logic [31:0] cp0_value;
    wb_t         wb;
    logic        overflow;
    mem_req_t    mem;
    hilo_wr_t    hilo;
    cp0_req_t    cp0;
    logic        syscall;
    logic        eret;
    logic        we_tlb;
    logic        priv;
    logic        stall;

    logic [63:0] vec [MAX_TESTS][NFIELDS];
    int          n_tests;
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          cycle_cnt;
    int          cycle_limit;

    tb_clock u_clock (.clk_o(clk), .rst_n_o(rst_n));

    ex_stage #(.MUL_CYCLES(3)) UUT (
        .clk(clk), .rst_n_i(rst_n), .exception_flush_i(flush),
        .req_i(req), .hilo_value_i(hilo_value), .cp0_value_i(cp0_value),
        .wb_o(wb), .overflow_o(overflow), .mem_o(mem), .hilo_o(hilo), .cp0_o(cp0),
        .syscall_o(syscall), .eret_o(eret), .we_tlb_o(we_tlb), .priv_o(priv),
        .stall_o(stall)
    );

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic load_tests();
        int    fd;
        int    rc;
        string line;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("could not open %s", DATA_FILE);
            return;
        end
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = "";
            rc = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") continue;
            rc = $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                vec[n_tests][0], vec[n_tests][1], vec[n_tests][2],
                vec[n_tests][3], vec[n_tests][4], vec[n_tests][5],
                vec[n_tests][6], vec[n_tests][7], vec[n_tests][8],
                vec[n_tests][9], vec[n_tests][10], vec[n_tests][11],
                vec[n_tests][12], vec[n_tests][13], vec[n_tests][14],
                vec[n_tests][15], vec[n_tests][16], vec[n_tests][17],
                vec[n_tests][18], vec[n_tests][19], vec[n_tests][20],
                vec[n_tests][21], vec[n_tests][22], vec[n_tests][23],
                vec[n_tests][24]);
            if (rc != NFIELDS) begin
                $display("test file line has %0d fields instead of %0d", rc, NFIELDS);
                err_cnt++;
            end else begin
                n_tests++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_test(input int i);
        req.op            = ex_op_e'(vec[i][0][7:0]);
        req.op_type       = op_type_e'(vec[i][1][1:0]);
        req.address       = vec[i][2][31:0];
        req.reg_s         = vec[i][3][4:0];
        req.reg_t         = vec[i][4][4:0];
        req.reg_d         = vec[i][5][4:0];
        req.s_value       = vec[i][6][31:0];
        req.t_value       = vec[i][7][31:0];
        req.immediate     = vec[i][8][15:0];
        req.flag_unsigned = vec[i][9][0];
        hilo_value        = vec[i][10];
        cp0_value         = vec[i][11][31:0];
    endtask

    task automatic check_outputs(input int i);
        compare_field("wb data", 64'(wb.data), vec[i][12]);
        compare_field("wb reg_addr", 64'(wb.reg_addr), vec[i][13]);
        compare_field("overflow", 64'(overflow), vec[i][14]);
        compare_field("mem access_op", 64'(mem.access_op), vec[i][15]);
        compare_field("mem access_sz", 64'(mem.access_sz), vec[i][16]);
        compare_field("mem addr", 64'(mem.addr), vec[i][17]);
        compare_field("hilo we", 64'(hilo.we), vec[i][18]);
        compare_field("hilo value", hilo.value, vec[i][19]);
        compare_field("cp0 we", 64'(cp0.we), vec[i][20]);
        compare_field("cp0 wr_addr", 64'(cp0.wr_addr), vec[i][21]);
        compare_field("cp0 rd_addr", 64'(cp0.rd_addr), vec[i][22]);
        compare_field("cp0 sel", 64'(cp0.sel), vec[i][23]);
        compare_field("strobes", 64'({syscall, eret, we_tlb, priv}), vec[i][24]);
    endtask

    // run limit, set once the tests are loaded
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: no end of tests after %0d cycles", cycle_cnt);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int  errs_before;
        logic multi;
        logic saw_stall;
        flush       = 1'b0;
        req         = '0;
        hilo_value  = 64'd0;
        cp0_value   = 32'd0;
        n_tests     = 0;
        err_cnt     = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        cycle_limit = 0;
        load_tests();
        cycle_limit = n_tests * 40 + 50;
        if (n_tests == 0) begin
            $display("no tests were loaded");
            err_cnt++;
        end
        wait (rst_n);
        for (int i = 0; i < n_tests; i++) begin
            errs_before = err_cnt;
            @(posedge clk);
            #1 drive_test(i);
            multi = req.op inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB, OP_DIV};
            #2;
            saw_stall = stall;
            while (stall) begin  // multi-cycle result pending
                @(posedge clk);
                #3;
            end
            if (multi && !saw_stall) begin
                $display("Fail at %0t ns: stall was not raised before the result", $time);
                err_cnt++;
            end
            check_outputs(i);
            if (err_cnt == errs_before) begin
                pass_cnt++;
                $display("test %0d %s ok", i, req.op.name());
            end else begin
                fail_cnt++;
                $display("test %0d %s had %0d mismatches", i, req.op.name(),
                         err_cnt - errs_before);
            end
        end
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;  // 4 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== rtl/ex_stage.sv ====
`default_nettype none

module ex_stage #(
    parameter int MUL_CYCLES = 3
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             exception_flush_i,
    input  ex_pkg::ex_req_t  req_i,
    input  logic [63:0]      hilo_value_i,
    input  logic [31:0]      cp0_value_i,
    output ex_pkg::wb_t      wb_o,
    output logic             overflow_o,
    output ex_pkg::mem_req_t mem_o,
    output ex_pkg::hilo_wr_t hilo_o,
    output ex_pkg::cp0_req_t cp0_o,
    output logic             syscall_o,
    output logic             eret_o,
    output logic             we_tlb_o,
    output logic             priv_o,
    output logic             stall_o
);
    import ex_pkg::*;

    wb_t         alu_wb;
    logic        alu_overflow;
    hilo_wr_t    alu_hilo;   // mthi, mtlo
    logic [63:0] md_result;
    logic        md_done;

    alu_unit u_alu (
        .req_i        (req_i),
        .hilo_value_i (hilo_value_i),
        .wb_o         (alu_wb),
        .overflow_o   (alu_overflow),
        .hilo_o       (alu_hilo)
    );

    muldiv_unit #(.MUL_CYCLES(MUL_CYCLES)) u_muldiv (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (exception_flush_i),
        .req_i        (req_i),
        .hilo_value_i (hilo_value_i),
        .result_o     (md_result),
        .done_o       (md_done)
    );

    ex_combine u_combine (
        .req_i          (req_i),
        .cp0_value_i    (cp0_value_i),
        .alu_wb_i       (alu_wb),
        .alu_overflow_i (alu_overflow),
        .alu_hilo_i     (alu_hilo),
        .md_result_i    (md_result),
        .md_done_i      (md_done),
        .wb_o           (wb_o),
        .overflow_o     (overflow_o),
        .mem_o          (mem_o),
        .hilo_o         (hilo_o),
        .cp0_o          (cp0_o),
        .syscall_o      (syscall_o),
        .eret_o         (eret_o),
        .we_tlb_o       (we_tlb_o),
        .priv_o         (priv_o),
        .stall_o        (stall_o)
    );

endmodule

`default_nettype wire

// ==== rtl/ex_combine.sv ====
`default_nettype none

module ex_combine (
    input  ex_pkg::ex_req_t  req_i,
    input  logic [31:0]      cp0_value_i,
    input  ex_pkg::wb_t      alu_wb_i,
    input  logic             alu_overflow_i,
    input  ex_pkg::hilo_wr_t alu_hilo_i,
    input  logic [63:0]      md_result_i,
    input  logic             md_done_i,
    output ex_pkg::wb_t      wb_o,
    output logic             overflow_o,
    output ex_pkg::mem_req_t mem_o,
    output ex_pkg::hilo_wr_t hilo_o,
    output ex_pkg::cp0_req_t cp0_o,
    output logic             syscall_o,
    output logic             eret_o,
    output logic             we_tlb_o,
    output logic             priv_o,
    output logic             stall_o
);
    import ex_pkg::*;

    logic [31:0] eff_addr;

    assign eff_addr = req_i.s_value + {{16{req_i.immediate[15]}}, req_i.immediate};

    // held until the unit pulses done
    assign stall_o = is_muldiv(req_i.op) && !md_done_i;

    always_comb begin
        wb_o       = alu_wb_i;
        overflow_o = alu_overflow_i;
        hilo_o     = alu_hilo_i;
        cp0_o      = '0;
        case (req_i.op)
            OP_MUL: begin
                wb_o.data     = md_result_i[31:0];
                wb_o.reg_addr = md_done_i ? req_i.reg_d : 5'd0;
            end
            OP_MULT, OP_MADD, OP_MSUB, OP_DIV: hilo_o = '{we: md_done_i, value: md_result_i};
            OP_MFC0: begin
                cp0_o.rd_addr = req_i.reg_d;
                cp0_o.sel     = req_i.immediate[2:0];
                wb_o          = '{data: cp0_value_i, reg_addr: req_i.reg_t};
            end
            OP_MTC0: begin
                cp0_o = '{we: 1'b1, wr_addr: req_i.reg_d, rd_addr: 5'd0,
                          sel: req_i.immediate[2:0]};
                wb_o  = '{data: req_i.t_value, reg_addr: 5'd0};  // data carries the cp0 value
            end
            default: ;
        endcase
    end

    always_comb begin
        mem_o = '{access_op: ACCESS_OP_D2R, access_sz: ACCESS_SZ_WORD, addr: 32'd0};
        if (req_i.op inside {OP_LB, OP_LH, OP_LW, OP_LL}) begin
            mem_o.access_op = ACCESS_OP_M2R;
            mem_o.addr      = eff_addr;
        end else if (req_i.op inside {OP_SB, OP_SH, OP_SW, OP_SC}) begin
            mem_o.access_op = ACCESS_OP_R2M;
            mem_o.addr      = eff_addr;
        end
        if (req_i.op inside {OP_LB, OP_SB}) begin
            mem_o.access_sz = ACCESS_SZ_BYTE;
        end else if (req_i.op inside {OP_LH, OP_SH}) begin
            mem_o.access_sz = ACCESS_SZ_HALF;
        end
    end

    assign syscall_o = req_i.op == OP_SYSCALL;
    assign eret_o    = req_i.op == OP_ERET;
    assign we_tlb_o  = req_i.op == OP_TLBWI;
    assign priv_o    = req_i.op inside {OP_MFC0, OP_MTC0, OP_CACHE, OP_ERET, OP_TLBWI};

endmodule

`default_nettype wire

// ==== rtl/muldiv_unit.sv ====
`default_nettype none

module muldiv_unit #(
    parameter int MUL_CYCLES = 3   // at least 2
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            flush_i,
    input  ex_pkg::ex_req_t req_i,
    input  logic [63:0]     hilo_value_i,
    output logic [63:0]     result_o,
    output logic            done_o
);
    import ex_pkg::*;

    typedef enum logic [1:0] {IDLE, MUL_RUN, DIV_RUN, DONE} md_state_e;

    md_state_e          state_q;
    logic [5:0]         cnt_q;
    ex_op_e             op_q;
    logic signed [32:0] a_q;
    logic signed [32:0] b_q;
    logic signed [63:0] prod;
    logic [31:0]        rem_q;
    logic [31:0]        quo_q;      // dividend shifts out as quotient shifts in
    logic [31:0]        divisor_q;
    logic               q_neg_q;
    logic               r_neg_q;
    logic [32:0]        rem_shift;
    logic [32:0]        diff;
    logic [31:0]        rem_next;
    logic [31:0]        quo_next;
    logic [63:0]        mul_final;
    logic [63:0]        result_q;
    logic               s_neg;
    logic               t_neg;
    logic               mul_last;
    logic               div_last;

    assign s_neg    = !req_i.flag_unsigned && req_i.s_value[31];
    assign t_neg    = !req_i.flag_unsigned && req_i.t_value[31];
    assign mul_last = (state_q == MUL_RUN) && (cnt_q == 6'(MUL_CYCLES - 1));
    assign div_last = (state_q == DIV_RUN) && (cnt_q == 6'd31);

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin  // flush aborts with no done
            state_q <= IDLE;
            cnt_q   <= 6'd0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (is_muldiv(req_i.op)) begin
                        state_q <= (req_i.op == OP_DIV) ? DIV_RUN : MUL_RUN;
                        cnt_q   <= (req_i.op == OP_DIV) ? 6'd0 : 6'd1;
                    end
                end
                MUL_RUN: begin
                    if (mul_last) state_q <= DONE;
                    else cnt_q <= cnt_q + 6'd1;
                end
                DIV_RUN: begin
                    if (div_last) state_q <= DONE;
                    else cnt_q <= cnt_q + 6'd1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // {sign, value} is the 33-bit signed or unsigned extension
    assign prod = 64'(a_q) * 64'(b_q);

    always_comb begin
        case (op_q)
            OP_MADD: mul_final = hilo_value_i + prod;
            OP_MSUB: mul_final = hilo_value_i - prod;
            default: mul_final = prod;
        endcase
    end

    // one restoring step per cycle
    assign rem_shift = {rem_q, quo_q[31]};
    assign diff      = rem_shift - {1'b0, divisor_q};
    assign rem_next  = diff[32] ? rem_shift[31:0] : diff[31:0];
    assign quo_next  = {quo_q[30:0], ~diff[32]};

    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            op_q      <= req_i.op;
            a_q       <= {s_neg, req_i.s_value};
            b_q       <= {t_neg, req_i.t_value};
            rem_q     <= 32'd0;
            quo_q     <= s_neg ? -req_i.s_value : req_i.s_value;
            divisor_q <= t_neg ? -req_i.t_value : req_i.t_value;
            q_neg_q   <= s_neg ^ t_neg;
            r_neg_q   <= s_neg;   // remainder takes the dividend sign
        end
        if (state_q == DIV_RUN) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
        if (mul_last) begin
            result_q <= mul_final;
        end
        if (div_last) begin
            result_q <= {(r_neg_q ? -rem_next : rem_next), (q_neg_q ? -quo_next : quo_next)};
        end
    end

    assign result_o = result_q;
    assign done_o   = state_q == DONE;

    assert property (@(posedge clk) disable iff (!rst_n_i) done_o |=> !done_o)
        else $error("muldiv_unit: done held for two cycles");

    assert property (@(posedge clk) disable iff (!rst_n_i)
        (state_q == IDLE && !is_muldiv(req_i.op)) |=> (state_q == IDLE))
        else $error("muldiv_unit: left idle without a multiply/divide op");

endmodule

`default_nettype wire

// ==== rtl/alu_unit.sv ====
`default_nettype none

module alu_unit (
    input  ex_pkg::ex_req_t  req_i,
    input  logic [63:0]      hilo_value_i,
    output ex_pkg::wb_t      wb_o,
    output logic             overflow_o,
    output ex_pkg::hilo_wr_t hilo_o
);
    import ex_pkg::*;

    logic        is_r;
    logic [31:0] sext_imm;
    logic [31:0] zext_imm;
    logic [31:0] arith_opnd;   // add, sub, slt
    logic [31:0] logic_opnd;   // and, or, xor
    logic [31:0] add_res;
    logic [31:0] sub_res;
    logic        add_ovf;
    logic        sub_ovf;
    logic        slt_res;
    logic [4:0]  shamt;
    logic [4:0]  rd_or_rt;
    logic [5:0]  clo_cnt;
    logic [5:0]  clz_cnt;

    assign is_r       = req_i.op_type == OPTYPE_R;
    assign sext_imm   = {{16{req_i.immediate[15]}}, req_i.immediate};
    assign zext_imm   = {16'b0, req_i.immediate};
    assign arith_opnd = is_r ? req_i.t_value : sext_imm;
    assign logic_opnd = is_r ? req_i.t_value : zext_imm;
    assign rd_or_rt   = is_r ? req_i.reg_d : req_i.reg_t;

    assign add_res = req_i.s_value + arith_opnd;
    assign sub_res = req_i.s_value - arith_opnd;

    // same-sign inputs flipping sign on add, opposite-sign on sub
    assign add_ovf = !req_i.flag_unsigned && (req_i.s_value[31] == arith_opnd[31])
                     && (add_res[31] != req_i.s_value[31]);
    assign sub_ovf = !req_i.flag_unsigned && (req_i.s_value[31] != arith_opnd[31])
                     && (sub_res[31] != req_i.s_value[31]);

    assign slt_res = req_i.flag_unsigned ? (req_i.s_value < arith_opnd)
                                         : ($signed(req_i.s_value) < $signed(arith_opnd));

    assign shamt = (req_i.op inside {OP_SLLV, OP_SRLV, OP_SRAV}) ? req_i.s_value[4:0]
                                                                : req_i.immediate[4:0];

    count_bit_word u_clo (.data_i(req_i.s_value), .bit_i(1'b1), .cnt_o(clo_cnt));
    count_bit_word u_clz (.data_i(req_i.s_value), .bit_i(1'b0), .cnt_o(clz_cnt));

    always_comb begin
        wb_o       = '0;
        overflow_o = 1'b0;
        hilo_o     = '0;
        case (req_i.op)
            OP_ADD: begin
                if (add_ovf) begin
                    overflow_o = 1'b1;  // result dropped
                end else begin
                    wb_o.data     = add_res;
                    wb_o.reg_addr = rd_or_rt;
                end
            end
            OP_SUB: begin
                if (sub_ovf) begin
                    overflow_o = 1'b1;
                end else begin
                    wb_o.data     = sub_res;
                    wb_o.reg_addr = rd_or_rt;
                end
            end
            OP_AND: wb_o = '{data: req_i.s_value & logic_opnd, reg_addr: rd_or_rt};
            OP_OR:  wb_o = '{data: req_i.s_value | logic_opnd, reg_addr: rd_or_rt};
            OP_XOR: wb_o = '{data: req_i.s_value ^ logic_opnd, reg_addr: rd_or_rt};
            OP_NOR: wb_o = '{data: ~(req_i.s_value | req_i.t_value), reg_addr: req_i.reg_d};
            OP_SLT: wb_o = '{data: {31'b0, slt_res}, reg_addr: rd_or_rt};
            OP_LU:  wb_o = '{data: {req_i.immediate, 16'b0}, reg_addr: req_i.reg_t};
            OP_SLL, OP_SLLV: begin
                wb_o.data     = req_i.t_value << shamt;
                wb_o.reg_addr = req_i.reg_d;
            end
            OP_SRL, OP_SRLV: begin
                wb_o.data     = req_i.t_value >> shamt;
                wb_o.reg_addr = req_i.reg_d;
            end
            OP_SRA, OP_SRAV: begin
                wb_o.data     = $signed(req_i.t_value) >>> shamt;
                wb_o.reg_addr = req_i.reg_d;
            end
            OP_CLO: wb_o = '{data: {26'b0, clo_cnt}, reg_addr: req_i.reg_d};
            OP_CLZ: wb_o = '{data: {26'b0, clz_cnt}, reg_addr: req_i.reg_d};
            OP_MOVN: begin
                if (req_i.t_value != 32'd0) begin
                    wb_o = '{data: req_i.s_value, reg_addr: req_i.reg_d};
                end
            end
            OP_MOVZ: begin
                if (req_i.t_value == 32'd0) begin
                    wb_o = '{data: req_i.s_value, reg_addr: req_i.reg_d};
                end
            end
            OP_JAL, OP_BGEZAL, OP_BLTZAL: wb_o = '{data: req_i.address, reg_addr: 5'd31};
            OP_JALR: wb_o = '{data: req_i.address, reg_addr: req_i.reg_d};
            OP_LB, OP_LH, OP_LW, OP_LL: wb_o.reg_addr = req_i.reg_t;  // data comes later
            OP_SB, OP_SH, OP_SW, OP_SC: wb_o = '{data: req_i.t_value, reg_addr: req_i.reg_t};
            OP_MFHI: wb_o = '{data: hilo_value_i[63:32], reg_addr: req_i.reg_d};
            OP_MFLO: wb_o = '{data: hilo_value_i[31:0], reg_addr: req_i.reg_d};
            OP_MTHI: hilo_o = '{we: 1'b1, value: {req_i.s_value, hilo_value_i[31:0]}};
            OP_MTLO: hilo_o = '{we: 1'b1, value: {hilo_value_i[63:32], req_i.s_value}};
            default: ;
        endcase
    end

    // an overflowing op must never reach the register file
    always_comb begin
        assert (!(overflow_o && wb_o.reg_addr != 5'd0))
            else $error("alu_unit: overflow with a live write-back address");
    end

endmodule

`default_nettype wire

// ==== rtl/count_bit_word.sv ====
`default_nettype none

module count_bit_word (
    input  logic [31:0] data_i,
    input  logic        bit_i,
    output logic [5:0]  cnt_o
);

    always_comb begin
        logic run;
        run   = 1'b1;
        cnt_o = 6'd0;
        // leading run from the msb, stops at first mismatch
        for (int i = 31; i >= 0; i--) begin
            run = run && (data_i[i] == bit_i);
            if (run) begin
                cnt_o = cnt_o + 6'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    typedef enum logic [7:0] {
        OP_NOP     = 8'h00, OP_ADD    = 8'h01, OP_SUB    = 8'h02, OP_AND    = 8'h03,
        OP_OR      = 8'h04, OP_XOR    = 8'h05, OP_NOR    = 8'h06, OP_SLT    = 8'h07,
        OP_SLL     = 8'h08, OP_SRL    = 8'h09, OP_SRA    = 8'h0a, OP_SLLV   = 8'h0b,
        OP_SRLV    = 8'h0c, OP_SRAV   = 8'h0d, OP_LU     = 8'h0e, OP_CLO    = 8'h0f,
        OP_CLZ     = 8'h10, OP_MOVN   = 8'h11, OP_MOVZ   = 8'h12, OP_JAL    = 8'h13,
        OP_JALR    = 8'h14, OP_BGEZAL = 8'h15, OP_BLTZAL = 8'h16, OP_LB     = 8'h17,
        OP_LH      = 8'h18, OP_LW     = 8'h19, OP_LL     = 8'h1a, OP_SB     = 8'h1b,
        OP_SH      = 8'h1c, OP_SW     = 8'h1d, OP_SC     = 8'h1e, OP_MFHI   = 8'h1f,
        OP_MFLO    = 8'h20, OP_MTHI   = 8'h21, OP_MTLO   = 8'h22, OP_MFC0   = 8'h23,
        OP_MTC0    = 8'h24, OP_MUL    = 8'h25, OP_MULT   = 8'h26, OP_MADD   = 8'h27,
        OP_MSUB    = 8'h28, OP_DIV    = 8'h29, OP_SYSCALL = 8'h2a, OP_ERET  = 8'h2b,
        OP_TLBWI   = 8'h2c, OP_CACHE  = 8'h2d
    } ex_op_e;

    // operand form, I and J both take the immediate
    typedef enum logic [1:0] {OPTYPE_R = 2'd0, OPTYPE_I = 2'd1, OPTYPE_J = 2'd2} op_type_e;

    typedef enum logic [1:0] {
        ACCESS_OP_D2R = 2'd0,  // no memory access
        ACCESS_OP_M2R = 2'd1,  // load
        ACCESS_OP_R2M = 2'd2   // store
    } access_op_e;

    typedef enum logic [1:0] {
        ACCESS_SZ_BYTE = 2'd0,
        ACCESS_SZ_HALF = 2'd1,
        ACCESS_SZ_WORD = 2'd2
    } access_sz_e;

    typedef struct packed {
        ex_op_e      op;
        op_type_e    op_type;
        logic [31:0] address;   // link value for jal and friends
        logic [4:0]  reg_s;
        logic [4:0]  reg_t;
        logic [4:0]  reg_d;
        logic [31:0] s_value;
        logic [31:0] t_value;
        logic [15:0] immediate;
        logic        flag_unsigned;
    } ex_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  reg_addr;  // 0 means no write
    } wb_t;

    typedef struct packed {
        access_op_e  access_op;
        access_sz_e  access_sz;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic        we;
        logic [63:0] value;     // {hi, lo}
    } hilo_wr_t;

    typedef struct packed {
        logic       we;
        logic [4:0] wr_addr;
        logic [4:0] rd_addr;
        logic [2:0] sel;
    } cp0_req_t;

    function automatic logic is_muldiv(ex_op_e op);
        return op inside {OP_MUL, OP_MULT, OP_MADD, OP_MSUB, OP_DIV};
    endfunction

endpackage

`default_nettype wire
